// ==== tb/nes_mem_tests.txt ====
# opcode addr(hex) data(hex) expected(hex, -- means taken from the models and the ROM rule)
# LOAD streams the whole ROM; writes ignore the expected column; DMARD data is cpu.addr high byte
LOAD  0000 00 --
CPURD 8000 00 00
CPURD 8001 00 --
CPURD 8123 00 --
CPURD C5A7 00 E2
CPURD FFFC 00 --
CPURD FFFF 00 --
CPURD 4000 00 00
CPURD 6ABC 5A 00
CPURD 7FFF 00 00
CPURD 2002 91 91
CPURD 3FFF 4E --
CPUWR 0005 A5 --
CPURD 0005 00 A5
CPURD 0805 00 --
CPURD 1005 00 --
CPURD 1805 00 --
CPUWR 07FF 3C --
CPURD 1FFF 00 3C
CPUWR 2005 66 --
CPUWR 4005 77 --
CPURD 0005 00 A5
CPURD 0805 00 --
CPUWR 0203 C8 --
VWR   2400 5E --
VRD   0400 00 5E
VWR   23C0 17 --
VRD   03C0 00 --
VWR   2000 E1 --
VRD   0000 00 --
OWR   0010 42 --
ORD   0010 00 42
OWR   00FF 9D --
ORD   00FF 00 --
DMARD 0203 80 C8
DMARD 8010 00 --
DMARD 0005 12 --
CPURD 0203 00 --

// ==== src.f ====
hdl/nes_mem_pkg.sv
hdl/nes_dpram.sv
hdl/nes_prg_loader.sv
hdl/nes_bus_ctrl.sv
hdl/nes_mem_top.sv
tb/tb_nes_mem.sv

// ==== Bender.yml ====
package:
  name: nes_mem

sources:
  - hdl/nes_mem_pkg.sv
  - hdl/nes_dpram.sv
  - hdl/nes_prg_loader.sv
  - hdl/nes_bus_ctrl.sv
  - hdl/nes_mem_top.sv
  - target: test
    files:
      - tb/tb_nes_mem.sv

// ==== tb/tb_nes_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_nes_mem;

    localparam string TESTS_FILE = "tb/nes_mem_tests.txt";

    logic                                   clk;
    logic                                   rst;
    nes_mem_pkg::cpu_bus_t                  cpu;
    logic                                   cpu_phase;
    nes_mem_pkg::ppu_mem_t                  ppu;
    logic [nes_mem_pkg::VRAM_AW-1:0]        ppu_vaddr;
    logic [nes_mem_pkg::OAM_AW-1:0]         ppu_oam_addr;
    logic [7:0]                             rx_byte;
    logic                                   rx_ready;
    logic [7:0]                             cpu_din;
    logic [7:0]                             ppu_vdata;
    logic [7:0]                             ppu_oam_data;
    logic                                   cpu_reset;

    // Parsed test lines
    string      op_q[$];
    logic [15:0] addr_q[$];
    logic [7:0] data_q[$];
    logic [7:0] exp_q[$];
    bit         derived_q[$];   // Expected value from the models
    bit         tests_ready;

    // Reference models, indexed like the DUT memories
    logic [7:0] sram_model [0:(1 << nes_mem_pkg::SRAM_AW) - 1];
    logic [7:0] vram_model [0:(1 << nes_mem_pkg::VRAM_AW) - 1];
    logic [7:0] oam_model  [0:(1 << nes_mem_pkg::OAM_AW) - 1];

    nes_mem_top DUT (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .cpu_phase    (cpu_phase),
        .cpu_din      (cpu_din),
        .cpu_reset    (cpu_reset),
        .ppu          (ppu),
        .ppu_vaddr    (ppu_vaddr),
        .ppu_oam_addr (ppu_oam_addr),
        .ppu_vdata    (ppu_vdata),
        .ppu_oam_data (ppu_oam_data),
        .rx_byte      (rx_byte),
        .rx_ready     (rx_ready)
    );

    always #4 clk = ~clk;       // 8 ns period

    // ------------------------------------------------------------
    // Expected values
    // ------------------------------------------------------------
    // ROM byte n holds n XOR n>>8
    function automatic logic [7:0] rom_rule(input logic [14:0] n);
        logic [14:0] mix;
        mix = n ^ (n >> 8);
        return mix[7:0];
    endfunction

    // CPU side memory map
    function automatic logic [7:0] cpu_read_expect(input logic [15:0] a, input logic [7:0] rdata);
        if (a < nes_mem_pkg::PPU_BASE) return sram_model[a[nes_mem_pkg::SRAM_AW-1:0]];
        if (a <= nes_mem_pkg::PPU_LAST) return rdata;       // Register window
        if (a < nes_mem_pkg::ROM_BASE) return 8'h00;        // Open space
        return rom_rule(a[nes_mem_pkg::ROM_AW-1:0]);
    endfunction

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error: %s = 0x%02h, expected 0x%02h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Bounded wait for cpu_reset to settle at a level
    task automatic wait_reset_level(input logic level, input int limit);
        int n;
        n = 0;
        while (cpu_reset !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
    endtask

    // ------------------------------------------------------------
    // Bus operations, all driven on the falling edge
    // ------------------------------------------------------------
    task automatic load_rom();
        int n;
        int gap;
        check_level("cpu_reset", cpu_reset, 1'b0);      // Idle before the first byte
        for (n = 0; n < nes_mem_pkg::PRG_LEN; n++) begin
            rx_ready = 1'b1;
            repeat (2) @(negedge clk);
            if (n == nes_mem_pkg::PRG_LEN - 1) check_level("cpu_reset", cpu_reset, 1'b1);
            rx_byte  = rom_rule(15'(n));    // Stable until the next drop
            rx_ready = 1'b0;
            gap = 4 + ($urandom % 4);
            repeat (gap) @(negedge clk);
            if (n == 0) begin
                wait_reset_level(1'b1, 8);
                check_level("cpu_reset", cpu_reset, 1'b1);
            end
        end
        wait_reset_level(1'b0, 8);
        check_level("cpu_reset", cpu_reset, 1'b0);
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        cpu.eawr  = a;
        cpu.dout  = d;
        cpu.wreq  = 1'b1;
        cpu_phase = 1'b1;
        repeat (3) @(negedge clk);
        cpu_phase = 1'b0;                   // Fall commits the write
        repeat (3) @(negedge clk);
        cpu.wreq  = 1'b0;
        if (a < nes_mem_pkg::PPU_BASE) sram_model[a[nes_mem_pkg::SRAM_AW-1:0]] = d;
    endtask

    task automatic vram_write(input logic [15:0] a, input logic [7:0] d);
        ppu.waddr = a;
        ppu.wdata = d;
        ppu.vreq  = 1'b1;
        repeat (2) @(negedge clk);
        ppu.wdata = ~d;                     // Held level must not write again
        repeat (4) @(negedge clk);
        ppu.vreq  = 1'b0;
        @(negedge clk);
        vram_model[a[nes_mem_pkg::VRAM_AW-1:0]] = d;
    endtask

    task automatic run_line(input int i);
        logic [15:0] a;
        logic [7:0]  d;
        a = addr_q[i];
        d = data_q[i];
        case (op_q[i])
            "LOAD":  load_rom();
            "CPUWR": cpu_write(a, d);
            "VWR":   vram_write(a, d);
            "CPURD": begin
                ppu.dma   = 1'b0;
                cpu.addr  = a;
                ppu.rdata = d;              // Only seen in the register window
                @(negedge clk);
                check_byte("cpu_din", cpu_din, derived_q[i] ? cpu_read_expect(a, d) : exp_q[i]);
            end
            "DMARD": begin
                ppu.dma   = 1'b1;
                ppu.waddr = a;
                cpu.addr  = {d, a[7:0]};    // Must be ignored while DMA runs
                @(negedge clk);
                check_byte("cpu_din", cpu_din,
                           derived_q[i] ? cpu_read_expect(a, ppu.rdata) : exp_q[i]);
                ppu.dma   = 1'b0;
            end
            "VRD": begin
                ppu_vaddr = a[nes_mem_pkg::VRAM_AW-1:0];
                @(negedge clk);
                check_byte("ppu_vdata", ppu_vdata,
                           derived_q[i] ? vram_model[a[nes_mem_pkg::VRAM_AW-1:0]] : exp_q[i]);
            end
            "OWR": begin
                ppu.waddr  = a;
                ppu.wdata  = d;
                ppu.oam_we = 1'b1;          // Single cycle pulse
                @(negedge clk);
                ppu.oam_we = 1'b0;
                oam_model[a[nes_mem_pkg::OAM_AW-1:0]] = d;
            end
            "ORD": begin
                ppu_oam_addr = a[nes_mem_pkg::OAM_AW-1:0];
                @(negedge clk);
                check_byte("ppu_oam_data", ppu_oam_data,
                           derived_q[i] ? oam_model[a[nes_mem_pkg::OAM_AW-1:0]] : exp_q[i]);
            end
            default: abort_run($sformatf("unknown opcode %s on test line %0d", op_q[i], i));
        endcase
    endtask

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------
    initial begin
        int limit;
        wait (tests_ready);
        limit = nes_mem_pkg::PRG_LEN * 40 + op_q.size() * 50;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("TEST FAILED");
        $fatal(1);
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int          fd;
        int          cnt;
        string       line;
        string       op;
        string       exp_s;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  e;
        clk = 1'b0;
        rst = 1'b1;
        cpu = '0;
        cpu_phase = 1'b0;
        ppu = '0;
        ppu_vaddr = '0;
        ppu_oam_addr = '0;
        rx_byte = 8'h00;
        rx_ready = 1'b0;
        tests_ready = 1'b0;
        void'($urandom(32'h9c1f));

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) abort_run({"cannot open the test data file ", TESTS_FILE});
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;   // Blank or comment
            cnt = $sscanf(line, "%s %h %h %s", op, a, d, exp_s);
            if (cnt != 4) abort_run({"malformed test line: ", line});
            e = 8'h00;
            if (exp_s != "--") void'($sscanf(exp_s, "%h", e));
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
            derived_q.push_back(exp_s == "--");
        end
        $fclose(fd);
        tests_ready = 1'b1;

        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_byte("cpu_din", cpu_din, 8'h00);      // Route reset to none

        for (int i = 0; i < op_q.size(); i++) begin
            run_line(i);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/nes_mem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// Memory and bus subsystem, controller plus loader plus four RAMs
module nes_mem_top (
    input  wire                               clk,
    input  wire                               rst,

    // CPU
    input  nes_mem_pkg::cpu_bus_t             cpu,
    input  wire                               cpu_phase,
    output logic [7:0]                        cpu_din,
    output logic                              cpu_reset,

    // PPU
    input  nes_mem_pkg::ppu_mem_t             ppu,
    input  wire [nes_mem_pkg::VRAM_AW-1:0]    ppu_vaddr,
    input  wire [nes_mem_pkg::OAM_AW-1:0]     ppu_oam_addr,
    output logic [7:0]                        ppu_vdata,
    output logic [7:0]                        ppu_oam_data,

    // Serial receiver
    input  wire [7:0]                         rx_byte,
    input  wire                               rx_ready
);

    // ------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------
    logic [nes_mem_pkg::SRAM_AW-1:0] sram_rd_addr;
    logic [nes_mem_pkg::ROM_AW-1:0]  rom_rd_addr;
    logic [nes_mem_pkg::ROM_AW-1:0]  rom_wr_addr;   // From the loader
    logic [7:0]                      rom_wr_data;
    logic                            rom_wr_en;
    logic                            sram_wr_en;
    logic                            vram_wr_en;
    logic                            oam_wr_en;
    logic [7:0]                      sram_q;
    logic [7:0]                      rom_q;

    nes_bus_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .cpu_phase    (cpu_phase),
        .ppu          (ppu),
        .sram_rd_addr (sram_rd_addr),
        .rom_rd_addr  (rom_rd_addr),
        .sram_wr_en   (sram_wr_en),
        .vram_wr_en   (vram_wr_en),
        .oam_wr_en    (oam_wr_en),
        .sram_q       (sram_q),
        .rom_q        (rom_q),
        .cpu_din      (cpu_din)
    );

    nes_prg_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .rx_byte      (rx_byte),
        .rx_ready     (rx_ready),
        .rom_wr_addr  (rom_wr_addr),
        .rom_wr_data  (rom_wr_data),
        .rom_wr_en    (rom_wr_en),
        .busy         (cpu_reset)       // CPU held while loading
    );

    // ------------------------------------------------------------
    // Memories
    // ------------------------------------------------------------
    // Work RAM, written from the CPU effective address
    nes_dpram #(.aw(nes_mem_pkg::SRAM_AW)) u_sram (
        .clk     (clk),
        .rd_addr (sram_rd_addr),
        .rd_data (sram_q),
        .wr_addr (cpu.eawr[nes_mem_pkg::SRAM_AW-1:0]),
        .wr_data (cpu.dout),
        .wr_en   (sram_wr_en)
    );

    // Program ROM, write side owned by the loader
    nes_dpram #(.aw(nes_mem_pkg::ROM_AW)) u_rom (
        .clk     (clk),
        .rd_addr (rom_rd_addr),
        .rd_data (rom_q),
        .wr_addr (rom_wr_addr),
        .wr_data (rom_wr_data),
        .wr_en   (rom_wr_en)
    );

    // Name tables
    nes_dpram #(.aw(nes_mem_pkg::VRAM_AW)) u_vram (
        .clk     (clk),
        .rd_addr (ppu_vaddr),
        .rd_data (ppu_vdata),
        .wr_addr (ppu.waddr[nes_mem_pkg::VRAM_AW-1:0]),
        .wr_data (ppu.wdata),
        .wr_en   (vram_wr_en)
    );

    // Sprite attribute table
    nes_dpram #(.aw(nes_mem_pkg::OAM_AW)) u_oam (
        .clk     (clk),
        .rd_addr (ppu_oam_addr),
        .rd_data (ppu_oam_data),
        .wr_addr (ppu.waddr[nes_mem_pkg::OAM_AW-1:0]),  // Low byte of DMA / OAMADDR
        .wr_data (ppu.wdata),
        .wr_en   (oam_wr_en)
    );

endmodule

`default_nettype wire

// ==== hdl/nes_bus_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

// Address decode, DMA steering, write strobes and CPU read routing
module nes_bus_ctrl (
    input  wire                               clk,
    input  wire                               rst,

    input  nes_mem_pkg::cpu_bus_t             cpu,
    input  wire                               cpu_phase,    // Slow CPU clock level
    input  nes_mem_pkg::ppu_mem_t             ppu,

    // Memory read addresses
    output logic [nes_mem_pkg::SRAM_AW-1:0]   sram_rd_addr,
    output logic [nes_mem_pkg::ROM_AW-1:0]    rom_rd_addr,

    // Write strobes
    output logic                              sram_wr_en,
    output logic                              vram_wr_en,
    output logic                              oam_wr_en,

    // Registered read data
    input  wire [7:0]                         sram_q,
    input  wire [7:0]                         rom_q,
    output logic [7:0]                        cpu_din
);

    // ------------------------------------------------------------
    // Address mux and decode
    // ------------------------------------------------------------
    logic [nes_mem_pkg::ADDR_W-1:0] cur_addr;
    nes_mem_pkg::mem_route_t        route;
    nes_mem_pkg::mem_route_t        route_q;    // Lined up with memory data
    logic [7:0]                     ppu_q;      // Window data, one cycle late

    // DMA takes over the CPU read path
    assign cur_addr = ppu.dma ? ppu.waddr : cpu.addr;

    assign sram_rd_addr = cur_addr[nes_mem_pkg::SRAM_AW-1:0];  // 2 KB mirror
    assign rom_rd_addr  = cur_addr[nes_mem_pkg::ROM_AW-1:0];

    always_comb begin
        if (cur_addr < nes_mem_pkg::PPU_BASE) begin
            route = nes_mem_pkg::ROUTE_SRAM;
        end else if (cur_addr <= nes_mem_pkg::PPU_LAST) begin
            route = nes_mem_pkg::ROUTE_PPU;
        end else if (cur_addr >= nes_mem_pkg::ROM_BASE) begin
            route = nes_mem_pkg::ROUTE_ROM;
        end else begin
            route = nes_mem_pkg::ROUTE_NONE;        // 4000-7FFF, nothing here
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            route_q <= nes_mem_pkg::ROUTE_NONE;
        end else begin
            route_q <= route;
        end
    end

    // Same latency as the RAM and ROM read registers
    always_ff @(posedge clk) begin
        ppu_q <= ppu.rdata;
    end

    always_comb begin
        case (route_q)
            nes_mem_pkg::ROUTE_SRAM: cpu_din = sram_q;
            nes_mem_pkg::ROUTE_PPU:  cpu_din = ppu_q;
            nes_mem_pkg::ROUTE_ROM:  cpu_din = rom_q;
            default:                 cpu_din = 8'h00;
        endcase
    end

    // ------------------------------------------------------------
    // Write strobes
    // ------------------------------------------------------------
    logic phase_q;          // Last cpu_phase sample
    logic vreq_q1;          // vreq one cycle back
    logic vreq_q2;          // vreq two cycles back

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q    <= 1'b0;
            vreq_q1    <= 1'b0;
            vreq_q2    <= 1'b0;
            sram_wr_en <= 1'b0;
        end else begin
            phase_q <= cpu_phase;
            vreq_q1 <= ppu.vreq;
            vreq_q2 <= vreq_q1;
            // Commit on the phase fall, only below the PPU window
            sram_wr_en <= phase_q && !cpu_phase && cpu.wreq
                          && (cpu.eawr < nes_mem_pkg::PPU_BASE);
        end
    end

    // Second high cycle of a fresh vreq, once per rise
    assign vram_wr_en = ppu.vreq & vreq_q1 & ~vreq_q2;
    assign oam_wr_en  = ppu.oam_we;             // Pulse goes straight through

    // VRAM and OAM share ppu.waddr / ppu.wdata as their write path
    a_ppu_wr_onehot : assert property (
        @(posedge clk) disable iff (rst) $onehot0({vram_wr_en, oam_wr_en})
    ) else $error("nes_bus_ctrl: VRAM and OAM written in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/nes_prg_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

// Serial byte stream to sequential program ROM writes
module nes_prg_loader (
    input  wire                              clk,
    input  wire                              rst,

    // Receiver side
    input  wire [7:0]                        rx_byte,
    input  wire                              rx_ready,

    // ROM write port
    output logic [nes_mem_pkg::ROM_AW-1:0]   rom_wr_addr,
    output logic [7:0]                       rom_wr_data,
    output logic                             rom_wr_en,

    output logic                             busy       // Holds CPU in reset
);

    // ------------------------------------------------------------
    // rx_ready sync and falling edge
    // ------------------------------------------------------------
    logic [1:0] rx_sync;        // Two stage synchronizer
    logic       rx_prev;        // Last synced sample
    logic       rx_fall;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b00;
            rx_prev <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx_ready};
            rx_prev <= rx_sync[1];
        end
    end

    assign rx_fall = rx_prev & ~rx_sync[1];     // 1 -> 0 seen

    // ------------------------------------------------------------
    // Address counter and write strobe
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rom_wr_addr <= '0;
            rom_wr_en   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            rom_wr_en <= rx_fall;               // One write per edge
            if (rx_fall) begin
                if (!busy) begin
                    busy        <= 1'b1;        // First byte opens the load
                    rom_wr_addr <= '0;
                end else begin
                    rom_wr_addr <= rom_wr_addr + 1'b1;
                end
            end
            // Last byte written, release the CPU next cycle
            if (rom_wr_en && rom_wr_addr == (nes_mem_pkg::PRG_LEN - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // Payload byte, taken at the edge
    always_ff @(posedge clk) begin
        if (rx_fall) begin
            rom_wr_data <= rx_byte;
        end
    end

    // Edge detect must never stretch a write over two cycles
    a_single_write : assert property (
        @(posedge clk) disable iff (rst) rom_wr_en |=> !rom_wr_en
    ) else $error("nes_prg_loader: back to back ROM writes");

endmodule

`default_nettype wire

// ==== hdl/nes_dpram.sv ====
`timescale 1ns/1ns
`default_nettype none

// Byte wide RAM, one registered read port and one write port
module nes_dpram #(
    parameter int aw = 11               // Address width, depth is 2**aw
) (
    input  wire          clk,

    // Read side
    input  wire [aw-1:0] rd_addr,
    output logic [7:0]   rd_data,

    // Write side
    input  wire [aw-1:0] wr_addr,
    input  wire [7:0]    wr_data,
    input  wire          wr_en
);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    logic [7:0] mem [0:(1 << aw) - 1];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, same address write gives the old byte
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // A write to an unknown address would corrupt the whole array
    a_wr_addr_known : assert property (
        @(posedge clk) wr_en |-> !$isunknown(wr_addr)
    ) else $error("nes_dpram: write with unknown address");

endmodule

`default_nettype wire

// ==== hdl/nes_mem_pkg.sv ====
`default_nettype none

package nes_mem_pkg;

    // ------------------------------------------------------------
    // Bus and memory sizes
    // ------------------------------------------------------------
    localparam int ADDR_W  = 16;    // CPU and PPU bus address
    localparam int SRAM_AW = 11;    // 2 KB work RAM
    localparam int ROM_AW  = 15;    // 32 KB program ROM
    localparam int VRAM_AW = 11;    // 2 KB name tables
    localparam int OAM_AW  = 8;     // 256 byte sprite table

    localparam int PRG_LEN = 32768; // Bytes per ROM load

    // ------------------------------------------------------------
    // Memory map
    // ------------------------------------------------------------
    // Work RAM below PPU_BASE, mirrored every 2 KB
    localparam logic [ADDR_W-1:0] PPU_BASE = 16'h2000;
    localparam logic [ADDR_W-1:0] PPU_LAST = 16'h3FFF;  // PPU register window end
    localparam logic [ADDR_W-1:0] ROM_BASE = 16'h8000;  // ROM up to the top

    // CPU side outputs
    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // Read address
        logic [ADDR_W-1:0] eawr;    // Effective write address
        logic [7:0]        dout;    // Write data
        logic              wreq;    // Write request level
    } cpu_bus_t;

    // PPU memory side outputs
    typedef struct packed {
        logic [ADDR_W-1:0] waddr;   // VRAM / OAM / DMA address
        logic [7:0]        wdata;   // VRAM / OAM write data
        logic [7:0]        rdata;   // Register window read data
        logic              vreq;    // VRAM write request level
        logic              oam_we;  // OAM write pulse
        logic              dma;     // Sprite DMA running
    } ppu_mem_t;

    // Read data source for the CPU
    typedef enum logic [1:0] {
        ROUTE_SRAM,
        ROUTE_PPU,
        ROUTE_ROM,
        ROUTE_NONE
    } mem_route_t;

endpackage

`default_nettype wire
